/* design/credit_fifo.sv */
`timescale 1ns/10ps
`include "dma_mm_consts.svh"

module credit_fifo import dma_mm_pkg::*; (
    input  logic        wb_clk_i,
    input  logic        wb_rst_i,
    input  logic        push_i,
    input  fetch_word_t push_word_i,
    output logic        credit_o,
    output logic        valid_o,
    output fetch_word_t pop_word_o,
    input  logic        pop_i
);

    localparam int DEPTH = `DMA_FIFO_DEPTH;
    localparam int PW    = $clog2(DEPTH);
    localparam int CW    = PW + 1;

    fetch_word_t   mem [DEPTH];
    logic [PW-1:0] wr_ptr;
    logic [PW-1:0] rd_ptr;
    logic [CW-1:0] count;
    logic          do_pop;

    // push never meets a full buffer, the credits see to that
    assign valid_o    = (count != '0);
    assign do_pop     = pop_i && valid_o;
    assign pop_word_o = mem[rd_ptr];

    always_ff @(posedge wb_clk_i) begin
        if (push_i) begin
            mem[wr_ptr] <= push_word_i;
        end
    end

    always_ff @(posedge wb_clk_i) begin
        if (wb_rst_i) begin
            wr_ptr   <= '0;
            rd_ptr   <= '0;
            count    <= '0;
            credit_o <= 1'b0;
        end else begin
            credit_o <= do_pop;  // one credit back per pop
            if (push_i) begin
                wr_ptr <= (wr_ptr == PW'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (do_pop) begin
                rd_ptr <= (rd_ptr == PW'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            end
            count <= count + CW'(push_i) - CW'(do_pop);
        end
    end

endmodule

/* design/dma_mm.sv */
`timescale 1ns/10ps
`include "dma_mm_consts.svh"

module dma_mm import dma_mm_pkg::*; (
    input  logic                   wb_clk_i,
    input  logic                   wb_rst_i,
    input  wb_req_t                wb_req_i,
    output logic                   wbs_ack_o,
    output logic [`DMA_DATA_W-1:0] wbs_dat_o,
    output sdram_req_t             sdram_req_o,
    input  sdram_rsp_t             sdram_rsp_i
);

    logic                   start;
    logic [`DMA_ADDR_W-1:0] base_a;
    logic [`DMA_ADDR_W-1:0] base_b;
    logic                   mm_done;
    res_rd_t                res_rd;
    logic [`DMA_DATA_W-1:0] res_dat;
    logic                   push;
    fetch_word_t            push_word;
    logic                   credit;
    logic                   fifo_valid;
    fetch_word_t            fifo_word;
    logic                   pop;

    wb_regs u_regs (
        .wb_clk_i  (wb_clk_i),
        .wb_rst_i  (wb_rst_i),
        .wb_req_i  (wb_req_i),
        .wbs_ack_o (wbs_ack_o),
        .wbs_dat_o (wbs_dat_o),
        .start_o   (start),
        .base_a_o  (base_a),
        .base_b_o  (base_b),
        .mm_done_i (mm_done),
        .res_rd_o  (res_rd),
        .res_dat_i (res_dat)
    );

    sdram_fetch u_fetch (
        .wb_clk_i    (wb_clk_i),
        .wb_rst_i    (wb_rst_i),
        .start_i     (start),
        .base_a_i    (base_a),
        .base_b_i    (base_b),
        .sdram_req_o (sdram_req_o),
        .sdram_rsp_i (sdram_rsp_i),
        .push_o      (push),
        .push_word_o (push_word),
        .credit_i    (credit)
    );

    credit_fifo u_fifo (
        .wb_clk_i    (wb_clk_i),
        .wb_rst_i    (wb_rst_i),
        .push_i      (push),
        .push_word_i (push_word),
        .credit_o    (credit),
        .valid_o     (fifo_valid),
        .pop_word_o  (fifo_word),
        .pop_i       (pop)
    );

    mm_engine u_mm (
        .wb_clk_i  (wb_clk_i),
        .wb_rst_i  (wb_rst_i),
        .valid_i   (fifo_valid),
        .word_i    (fifo_word),
        .pop_o     (pop),
        .mm_done_o (mm_done),
        .res_rd_i  (res_rd),
        .res_dat_o (res_dat)
    );

endmodule

/* design/dma_mm_consts.svh */
`ifndef DMA_MM_CONSTS_SVH
`define DMA_MM_CONSTS_SVH

// datapath widths
`define DMA_DATA_W      32
`define DMA_ADDR_W      23

`define DMA_MAT_N       4      // square matrix, N x N

// buffer entries, also the fetcher's starting credits
`define DMA_FIFO_DEPTH  4

// byte strides in SDRAM, row major layout
`define DMA_ROW_STRIDE  16
`define DMA_COL_STRIDE  4

// register map, low address byte
`define DMA_REG_CTRL    8'h00
`define DMA_REG_BASE_A  8'h04
`define DMA_REG_BASE_B  8'h08
`define DMA_REG_RES0    8'h0C  // first of N*N result words

`endif

/* design/dma_mm_pkg.sv */
`include "dma_mm_consts.svh"

package dma_mm_pkg;

    // wishbone request from the host side
    typedef struct packed {
        logic                   cyc;
        logic                   stb;
        logic                   we;
        logic [7:0]             addr;   // only the low byte is decoded
        logic [`DMA_DATA_W-1:0] dat;
    } wb_req_t;

    typedef struct packed {
        logic                   valid;
        logic [`DMA_ADDR_W-1:0] addr;
    } sdram_req_t;

    typedef struct packed {
        logic                   busy;
        logic                   out_valid;
        logic [`DMA_DATA_W-1:0] data;
    } sdram_rsp_t;

    // word on its way from the fetcher to the engine
    typedef struct packed {
        logic                   is_b;   // set for B elements
        logic [`DMA_DATA_W-1:0] data;
    } fetch_word_t;

    typedef struct packed {
        logic [$clog2(`DMA_MAT_N*`DMA_MAT_N)-1:0] idx;
    } res_rd_t;

endpackage

/* design/mm_engine.sv */
`timescale 1ns/10ps
`include "dma_mm_consts.svh"

module mm_engine import dma_mm_pkg::*; (
    input  logic                   wb_clk_i,
    input  logic                   wb_rst_i,
    input  logic                   valid_i,
    input  fetch_word_t            word_i,
    output logic                   pop_o,
    output logic                   mm_done_o,
    input  res_rd_t                res_rd_i,
    output logic [`DMA_DATA_W-1:0] res_dat_o
);

    localparam int N  = `DMA_MAT_N;
    localparam int DW = `DMA_DATA_W;
    localparam int IW = $clog2(N);
    localparam int BW = 2 * IW;

    logic [DW-1:0] b_mat [N][N];   // [k][j]
    logic [DW-1:0] a_row [N];
    logic [DW-1:0] res_mem [N*N];
    logic [BW-1:0] b_cnt;          // column major fill
    logic [IW-1:0] a_cnt;
    logic [IW-1:0] row;
    logic [IW-1:0] col;
    logic          b_full;
    logic          a_full;
    logic          take_a;
    logic          take_b;
    logic          calc;
    logic [DW-1:0] dot;

    // A words stay in the buffer while a row is busy, which stalls the fetch
    assign pop_o  = valid_i && (word_i.is_b ? !b_full : !a_full);
    assign take_b = pop_o && word_i.is_b;
    assign take_a = pop_o && !word_i.is_b;
    assign calc   = a_full && b_full;

    always_comb begin
        dot = '0;
        for (int k = 0; k < N; k++) begin
            dot = dot + a_row[k] * b_mat[k][col];  // low 32 bits kept
        end
    end

    assign res_dat_o = res_mem[res_rd_i.idx];

    always_ff @(posedge wb_clk_i) begin
        if (take_b) begin
            b_mat[b_cnt[IW-1:0]][b_cnt[BW-1:IW]] <= word_i.data;
        end
        if (take_a) begin
            a_row[a_cnt] <= word_i.data;
        end
        if (calc) begin
            res_mem[{row, col}] <= dot;
        end
    end

    always_ff @(posedge wb_clk_i) begin
        if (wb_rst_i) begin
            b_cnt     <= '0;
            a_cnt     <= '0;
            row       <= '0;
            col       <= '0;
            b_full    <= 1'b0;
            a_full    <= 1'b0;
            mm_done_o <= 1'b0;
        end else begin
            if (take_b) begin
                b_cnt <= b_cnt + 1'b1;
                if (b_cnt == BW'(N * N - 1)) b_full <= 1'b1;
            end
            if (take_a) begin
                a_cnt <= (a_cnt == IW'(N - 1)) ? '0 : a_cnt + 1'b1;
                if (a_cnt == IW'(N - 1)) a_full <= 1'b1;
            end
            if (calc) begin
                col <= (col == IW'(N - 1)) ? '0 : col + 1'b1;
                if (col == IW'(N - 1)) begin
                    a_full <= 1'b0;  // row done, accept the next one
                    row    <= row + 1'b1;
                    if (row == IW'(N - 1)) mm_done_o <= 1'b1;
                end
            end
        end
    end

endmodule

/* design/sdram_fetch.sv */
`timescale 1ns/10ps
`include "dma_mm_consts.svh"

module sdram_fetch import dma_mm_pkg::*; (
    input  logic                   wb_clk_i,
    input  logic                   wb_rst_i,
    input  logic                   start_i,
    input  logic [`DMA_ADDR_W-1:0] base_a_i,
    input  logic [`DMA_ADDR_W-1:0] base_b_i,
    output sdram_req_t             sdram_req_o,
    input  sdram_rsp_t             sdram_rsp_i,
    output logic                   push_o,
    output fetch_word_t            push_word_o,
    input  logic                   credit_i
);

    localparam int N    = `DMA_MAT_N;
    localparam int AW   = `DMA_ADDR_W;
    localparam int IW   = $clog2(N);
    localparam int SEGS = 2 * N;  // A row 0, B columns, remaining A rows
    localparam int SW   = $clog2(SEGS);
    localparam int CW   = $clog2(`DMA_FIFO_DEPTH + 1);

    typedef enum logic [2:0] {
        F_IDLE,
        F_HOLD,
        F_REQ,
        F_WAIT,
        F_DONE
    } fstate_t;

    fstate_t       state;
    logic [SW-1:0] seg;      // coarse counter
    logic [IW-1:0] elem;     // fine counter
    logic [CW-1:0] credits;
    logic          seg_is_b;
    logic [IW-1:0] major;
    logic [AW-1:0] next_addr;
    logic          issue;
    logic          take;
    logic          last;

    assign seg_is_b = (seg != '0) && (seg <= N);

    always_comb begin
        if (seg == '0) begin
            major = '0;
        end else if (seg_is_b) begin
            major = IW'(seg - 1);  // B column
        end else begin
            major = IW'(seg - N);  // A row 1 and up
        end
    end

    always_comb begin
        if (seg_is_b) begin
            next_addr = base_b_i + AW'(major) * AW'(`DMA_COL_STRIDE) +
                        AW'(elem) * AW'(`DMA_ROW_STRIDE);
        end else begin
            next_addr = base_a_i + AW'(major) * AW'(`DMA_ROW_STRIDE) +
                        AW'(elem) * AW'(`DMA_COL_STRIDE);
        end
    end

    assign issue = ((state == F_IDLE && start_i) || state == F_HOLD) && (credits != '0);
    assign take  = (state == F_REQ) && !sdram_rsp_i.busy;
    assign last  = (seg == SW'(SEGS - 1)) && (elem == IW'(N - 1));

    always_ff @(posedge wb_clk_i) begin
        if (wb_rst_i) begin
            state       <= F_IDLE;
            seg         <= '0;
            elem        <= '0;
            credits     <= CW'(`DMA_FIFO_DEPTH);
            sdram_req_o <= '0;
            push_o      <= 1'b0;
        end else begin
            push_o  <= 1'b0;
            credits <= credits + CW'(credit_i) - CW'(issue);
            if (issue) begin
                sdram_req_o.valid <= 1'b1;
                sdram_req_o.addr  <= next_addr;
                state             <= F_REQ;
            end else begin
                case (state)
                    F_IDLE: if (start_i) state <= F_HOLD;  // no credit yet
                    F_REQ: begin
                        if (take) begin
                            sdram_req_o.valid <= 1'b0;
                            state             <= F_WAIT;
                        end
                    end
                    F_WAIT: begin
                        if (sdram_rsp_i.out_valid) begin
                            push_o <= 1'b1;
                            if (last) begin
                                state <= F_DONE;
                            end else begin
                                state <= F_HOLD;
                                if (elem == IW'(N - 1)) begin
                                    elem <= '0;
                                    seg  <= seg + 1'b1;
                                end else begin
                                    elem <= elem + 1'b1;
                                end
                            end
                        end
                    end
                    default: ;  // hold and done wait here
                endcase
            end
        end
    end

    always_ff @(posedge wb_clk_i) begin
        if (state == F_WAIT && sdram_rsp_i.out_valid) begin
            push_word_o.is_b <= seg_is_b;
            push_word_o.data <= sdram_rsp_i.data;
        end
    end

endmodule

/* design/wb_regs.sv */
`timescale 1ns/10ps
`include "dma_mm_consts.svh"

module wb_regs import dma_mm_pkg::*; (
    input  logic                   wb_clk_i,
    input  logic                   wb_rst_i,
    input  wb_req_t                wb_req_i,
    output logic                   wbs_ack_o,
    output logic [`DMA_DATA_W-1:0] wbs_dat_o,
    output logic                   start_o,
    output logic [`DMA_ADDR_W-1:0] base_a_o,
    output logic [`DMA_ADDR_W-1:0] base_b_o,
    input  logic                   mm_done_i,
    output res_rd_t                res_rd_o,
    input  logic [`DMA_DATA_W-1:0] res_dat_i
);

    localparam int DW = `DMA_DATA_W;
    localparam int AW = `DMA_ADDR_W;

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_RUN,
        ST_DONE
    } state_t;

    state_t        state;
    logic          access;
    logic          wr;
    logic [7:0]    res_off;
    logic          res_hit;
    logic [DW-1:0] rd_data;

    assign access = wb_req_i.cyc && wb_req_i.stb && !wbs_ack_o;  // one ack per request
    assign wr     = access && wb_req_i.we;

    assign res_off      = wb_req_i.addr - `DMA_REG_RES0;
    assign res_hit      = (wb_req_i.addr >= `DMA_REG_RES0) && (res_off[7:6] == 2'b00) &&
                          (res_off[1:0] == 2'b00);
    assign res_rd_o.idx = res_off[5:2];

    always_comb begin
        case (wb_req_i.addr)
            `DMA_REG_CTRL: begin
                case (state)
                    ST_IDLE: rd_data = 32'd4;  // {idle, done, start}
                    ST_DONE: rd_data = 32'd2;
                    default: rd_data = '0;
                endcase
            end
            `DMA_REG_BASE_A: rd_data = {{(DW-AW){1'b0}}, base_a_o};
            `DMA_REG_BASE_B: rd_data = {{(DW-AW){1'b0}}, base_b_o};
            default:         rd_data = (res_hit && state == ST_DONE) ? res_dat_i : '0;
        endcase
    end

    always_ff @(posedge wb_clk_i) begin
        if (wb_rst_i) begin
            wbs_ack_o <= 1'b0;
            start_o   <= 1'b0;
            state     <= ST_IDLE;
            base_a_o  <= '0;
            base_b_o  <= '0;
        end else begin
            wbs_ack_o <= access;
            start_o   <= 1'b0;
            if (wr) begin
                case (wb_req_i.addr)
                    `DMA_REG_CTRL: begin
                        if (state == ST_IDLE && wb_req_i.dat[0]) begin
                            start_o <= 1'b1;
                            state   <= ST_RUN;
                        end
                    end
                    `DMA_REG_BASE_A: base_a_o <= wb_req_i.dat[AW-1:0];
                    `DMA_REG_BASE_B: base_b_o <= wb_req_i.dat[AW-1:0];
                    default: ;  // results are read only
                endcase
            end
            if (state == ST_RUN && mm_done_i) begin
                state <= ST_DONE;  // held until reset
            end
        end
    end

    // read data lines up with ack
    always_ff @(posedge wb_clk_i) begin
        if (access) begin
            wbs_dat_o <= wb_req_i.we ? '0 : rd_data;
        end
    end

endmodule

/* dma_mm.f */
+incdir+design
design/dma_mm_pkg.sv
design/wb_regs.sv
design/sdram_fetch.sv
design/credit_fifo.sv
design/mm_engine.sv
design/dma_mm.sv
tests/sdram_model.sv
tests/tb_dma_mm.sv

/* run.sh */
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
    --top-module tb_dma_mm -f dma_mm.f -o sim_dma_mm

out=$(./obj_dir/sim_dma_mm)
echo "$out"
echo "$out" | grep -q "^TESTS PASSED$"

/* tests/sdram_model.sv */
`timescale 1ns/10ps
`include "dma_mm_consts.svh"

module sdram_model import dma_mm_pkg::*; #(
    parameter int MEM_AW       = 10,
    parameter int LAT_MAX      = 6,
    parameter int BUSY_RUN_MAX = 8
) (
    input  logic       wb_clk_i,
    input  logic       wb_rst_i,
    input  logic [6:0] busy_pct_i,
    input  sdram_req_t sdram_req_i,
    output sdram_rsp_t sdram_rsp_o
);

    logic [`DMA_DATA_W-1:0] mem [2**MEM_AW];
    logic [`DMA_ADDR_W-1:0] addr_log [$];   // accepted requests, in order
    logic [`DMA_ADDR_W-1:0] cur_addr;
    logic                   pending;
    int                     lat;
    int                     busy_run;

    task automatic fill_mem();
        for (int i = 0; i < 2**MEM_AW; i++) begin
            mem[i] = $urandom & 32'hff;  // small operands
        end
    endtask

    always @(posedge wb_clk_i) begin
        if (wb_rst_i) begin
            sdram_rsp_o <= '0;
            pending     <= 1'b0;
            busy_run    <= 0;
            lat         <= 0;
            addr_log.delete();
        end else begin
            sdram_rsp_o.out_valid <= 1'b0;
            if (busy_run < BUSY_RUN_MAX && ($urandom % 100) < busy_pct_i) begin
                sdram_rsp_o.busy <= 1'b1;
                busy_run         <= busy_run + 1;
            end else begin
                sdram_rsp_o.busy <= 1'b0;  // busy runs stay bounded
                busy_run         <= 0;
            end
            if (sdram_req_i.valid && !sdram_rsp_o.busy && !pending) begin
                addr_log.push_back(sdram_req_i.addr);
                cur_addr <= sdram_req_i.addr;
                lat      <= 1 + int'($urandom % LAT_MAX);
                pending  <= 1'b1;
            end else if (pending) begin
                if (lat == 1) begin
                    sdram_rsp_o.out_valid <= 1'b1;
                    sdram_rsp_o.data      <= mem[cur_addr[MEM_AW-1:0]];
                    pending               <= 1'b0;
                end else begin
                    lat <= lat - 1;
                end
            end
        end
    end

endmodule

/* tests/tb_dma_mm.sv */
`timescale 1ns/10ps
`include "dma_mm_consts.svh"

module tb_dma_mm import dma_mm_pkg::*; ();

    localparam int CLK_PERIOD   = 100;
    localparam int N            = `DMA_MAT_N;
    localparam int WORDS        = 2 * N * N;
    localparam int MEM_AW       = 10;
    localparam int LAT_MAX      = 6;
    localparam int BUSY_RUN_MAX = 8;
    localparam int WORD_MAX_CYC = BUSY_RUN_MAX + LAT_MAX + 8;  // plus fetch and engine turnaround
    localparam int RUN_CYC      = WORDS * WORD_MAX_CYC + 300;  // wishbone traffic on top
    localparam int N_RUNS       = 2;
    localparam int ACK_TIMEOUT  = 8;

    logic                   wb_clk;
    logic                   wb_rst;
    wb_req_t                wb_req;
    logic                   wbs_ack;
    logic [`DMA_DATA_W-1:0] wbs_dat;
    sdram_req_t             sdram_req;
    sdram_rsp_t             sdram_rsp;
    logic [6:0]             busy_pct;
    logic                   ack_q = 1'b0;
    string                  cur_test;
    int                     test_errs;
    int                     tests_run;
    int                     tests_failed;
    int                     proto_errs;

    dma_mm dut (
        .wb_clk_i    (wb_clk),
        .wb_rst_i    (wb_rst),
        .wb_req_i    (wb_req),
        .wbs_ack_o   (wbs_ack),
        .wbs_dat_o   (wbs_dat),
        .sdram_req_o (sdram_req),
        .sdram_rsp_i (sdram_rsp)
    );

    sdram_model #(
        .MEM_AW       (MEM_AW),
        .LAT_MAX      (LAT_MAX),
        .BUSY_RUN_MAX (BUSY_RUN_MAX)
    ) mem_model (
        .wb_clk_i    (wb_clk),
        .wb_rst_i    (wb_rst),
        .busy_pct_i  (busy_pct),
        .sdram_req_i (sdram_req),
        .sdram_rsp_o (sdram_rsp)
    );

    initial begin
        wb_clk = 1'b0;
        forever #(CLK_PERIOD / 2) wb_clk = ~wb_clk;
    end

    initial begin
        #(N_RUNS * RUN_CYC * CLK_PERIOD);
        $display("watchdog expired before the tests finished");
        $display("TESTS FAILED");
        $finish;
    end

    // ack must drop after every single-cycle pulse
    always @(negedge wb_clk) begin
        if (!wb_rst) begin
            assert (!(wbs_ack && ack_q)) else begin
                $display("acknowledge was high in two consecutive cycles");
                proto_errs++;
            end
        end
        ack_q = wbs_ack;
    end

    task automatic check_value(string what, logic [31:0] exp, logic [31:0] got);
        assert (got === exp) else begin
            $display("MISMATCH %s %s: expected 0x%08h, actual 0x%08h", cur_test, what, exp, got);
            test_errs++;
        end
    endtask

    task automatic start_test(string name);
        cur_test  = name;
        test_errs = 0;
    endtask

    task automatic finish_test();
        tests_run++;
        if (test_errs != 0) tests_failed++;
        $display("%-20s %s (%0d errors)", cur_test, (test_errs == 0) ? "ok" : "failed", test_errs);
    endtask

    task automatic apply_reset();
        @(posedge wb_clk);
        wb_rst <= 1'b1;
        repeat (2) @(posedge wb_clk);
        wb_rst <= 1'b0;
    endtask

    // one wishbone access, ack and data sampled mid cycle
    task automatic wb_access(input logic we, input logic [7:0] addr, input logic [31:0] wdat,
                             output logic [31:0] rdat, output int lat);
        @(posedge wb_clk);
        wb_req <= '{cyc: 1'b1, stb: 1'b1, we: we, addr: addr, dat: wdat};
        lat = 0;
        @(negedge wb_clk);
        while (!wbs_ack && lat < ACK_TIMEOUT) begin
            @(negedge wb_clk);
            lat++;
        end
        assert (wbs_ack) else begin
            $display("%s: no acknowledge for offset 0x%02h", cur_test, addr);
            test_errs++;
        end
        rdat = wbs_dat;
        @(posedge wb_clk);
        wb_req <= '0;
    endtask

    task automatic wb_write(logic [7:0] addr, logic [31:0] data);
        logic [31:0] unused;
        int          lat;
        wb_access(1'b1, addr, data, unused, lat);
    endtask

    function automatic logic [22:0] elem_addr(logic [22:0] base, int row, int col);
        return base + 23'(row * `DMA_ROW_STRIDE + col * `DMA_COL_STRIDE);
    endfunction

    function automatic logic [31:0] mem_word(logic [22:0] addr);
        return mem_model.mem[addr[MEM_AW-1:0]];
    endfunction

    task automatic run_matmul(string tag, logic [31:0] wr_a, logic [31:0] wr_b, logic [6:0] pct);
        logic [31:0] rd;
        logic [31:0] acc;
        logic [22:0] ba;
        logic [22:0] bb;
        logic [22:0] order [$];
        int          lat;
        int          polls;

        ba = wr_a[22:0];
        bb = wr_b[22:0];
        @(posedge wb_clk);
        busy_pct <= pct;
        apply_reset();

        start_test({tag, "_reset_status"});
        wb_access(1'b0, `DMA_REG_CTRL, '0, rd, lat);
        check_value("ack latency", 1, lat);
        check_value("ctrl", 32'd4, rd);
        finish_test();

        start_test({tag, "_base_regs"});
        wb_write(`DMA_REG_BASE_A, wr_a);
        wb_write(`DMA_REG_BASE_B, wr_b);
        wb_access(1'b0, `DMA_REG_BASE_A, '0, rd, lat);
        check_value("base a", 32'(ba), rd);
        wb_access(1'b0, `DMA_REG_BASE_B, '0, rd, lat);
        check_value("base b", 32'(bb), rd);
        finish_test();

        start_test({tag, "_status_poll"});
        wb_write(`DMA_REG_CTRL, 32'd1);
        wb_access(1'b0, `DMA_REG_RES0, '0, rd, lat);
        check_value("result before done", 32'd0, rd);
        polls = 0;
        rd    = '0;
        while (rd != 32'd2 && polls < RUN_CYC) begin
            wb_access(1'b0, `DMA_REG_CTRL, '0, rd, lat);
            polls++;
            if (rd != 32'd2) check_value("ctrl while running", 32'd0, rd);
        end
        assert (rd == 32'd2) else begin
            $display("%s: status never reached done", cur_test);
            test_errs++;
        end
        repeat (2) begin
            wb_access(1'b0, `DMA_REG_CTRL, '0, rd, lat);
            check_value("ctrl after done", 32'd2, rd);
        end
        finish_test();

        start_test({tag, "_fetch_order"});
        for (int c = 0; c < N; c++) order.push_back(elem_addr(ba, 0, c));
        for (int j = 0; j < N; j++) begin
            for (int k = 0; k < N; k++) order.push_back(elem_addr(bb, k, j));  // B by column
        end
        for (int r = 1; r < N; r++) begin
            for (int c = 0; c < N; c++) order.push_back(elem_addr(ba, r, c));
        end
        check_value("request count", WORDS, mem_model.addr_log.size());
        for (int i = 0; i < WORDS && i < mem_model.addr_log.size(); i++) begin
            check_value($sformatf("request %0d", i), 32'(order[i]), 32'(mem_model.addr_log[i]));
        end
        check_value("request valid after last", 32'd0, 32'(sdram_req.valid));
        finish_test();

        start_test({tag, "_results"});
        for (int r = 0; r < N; r++) begin
            for (int j = 0; j < N; j++) begin
                acc = '0;
                for (int k = 0; k < N; k++) begin
                    acc = acc + mem_word(elem_addr(ba, r, k)) * mem_word(elem_addr(bb, k, j));
                end
                wb_access(1'b0, 8'(`DMA_REG_RES0 + 4 * (r * N + j)), '0, rd, lat);
                check_value($sformatf("c[%0d][%0d]", r, j), acc, rd);
            end
        end
        finish_test();
    endtask

    initial begin
        wb_rst       = 1'b1;
        wb_req       = '0;
        busy_pct     = '0;
        tests_run    = 0;
        tests_failed = 0;
        proto_errs   = 0;
        void'($urandom(32'h485));
        mem_model.fill_mem();
        run_matmul("run1", 32'hABC0_0100, 32'h1234_0200, 7'd25);
        run_matmul("run2", 32'h0000_0380, 32'hFFFF_FFC8, 7'd70);  // B wraps past the top
        $display("%0d tests, %0d failed, %0d protocol errors", tests_run, tests_failed, proto_errs);
        if (tests_failed == 0 && proto_errs == 0) begin
            $display("TESTS PASSED");
        end else begin
            $display("TESTS FAILED");
        end
        $finish;
    end

endmodule
